// ==== mem_types_pkg.sv ====
////////////////////
// shared types and constants for the memory subsystem
// modules pull these in with a wildcard import in their header
////////////////////
package mem_types_pkg;

  // data path and address widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // ram geometry of 64 words
  // word index is taken from address bits 7 down to 2
  localparam int RAM_DEPTH_LOG2 = 6;
  localparam int RAM_DEPTH = 1 << RAM_DEPTH_LOG2;

  // number of busy cycles before the access cycle
  localparam int RAM_LATENCY = 3;
  // enough bits to count the busy cycles down
  localparam int LAT_CNT_W = $clog2(RAM_LATENCY + 1);

  // one data word
  typedef logic [WORD_W-1:0] word_t;
  // byte address, low two bits ignored
  typedef logic [ADDR_W-1:0] addr_t;
  // word index into the ram array
  typedef logic [RAM_DEPTH_LOG2-1:0] word_idx_t;
  // latency down-counter
  typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

  // ram condition in the current cycle
  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS
  } ram_state_t;

endpackage

// ==== memory_control.sv ====
////////////////////
// arbiter and sequencer between the instruction port, the data port
// and the single word-wide ram
// data requests win over instruction fetches
// one access in flight
////////////////////
`timescale 1ns/100ps

module memory_control
  import mem_types_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  // instruction requester
  input  logic       iREN,
  input  addr_t      iaddr,
  // data requester
  input  logic       dREN,
  input  logic       dWEN,
  input  addr_t      daddr,
  input  word_t      dstore,
  // replies to the requesters
  output logic       iwait,
  output logic       dwait,
  output word_t      iload,
  output word_t      dload,
  // ram side
  output logic       ramREN,
  output logic       ramWEN,
  output addr_t      ramaddr,
  output word_t      ramstore,
  input  ram_state_t ramstate,
  input  word_t      ramload
);

  // sequencer states
  // read and write states hold the ram strobe until access
  // grab and send states last one cycle and present the word
  typedef enum logic [2:0] {
    IDLE,
    READ_INSTR,
    GRAB_INSTR,
    READ_DATA,
    GRAB_DATA,
    WRITE_DATA,
    SEND_DATA
  } ctrl_state_t;

  ctrl_state_t state, next_state;

  // decoded data request
  // both strobes high counts as no request
  logic d_read_req;
  logic d_write_req;

  // word captured on the access cycle
  word_t load_q;

  assign d_read_req  = dREN & ~dWEN;
  assign d_write_req = dWEN & ~dREN;

  // next state decode
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // data port has priority
        if (d_read_req) begin
          next_state = READ_DATA;
        end else if (d_write_req) begin
          next_state = WRITE_DATA;
        end else if (iREN) begin
          // fetch only when the data port is quiet
          next_state = READ_INSTR;
        end
      end
      READ_INSTR: begin
        // wait through free and busy until the ram reports access
        if (ramstate == ACCESS) begin
          next_state = GRAB_INSTR;
        end
      end
      READ_DATA: begin
        if (ramstate == ACCESS) begin
          next_state = GRAB_DATA;
        end
      end
      WRITE_DATA: begin
        // write is committed at the edge leaving access
        if (ramstate == ACCESS) begin
          next_state = SEND_DATA;
        end
      end
      // completion cycles always go back to idle
      GRAB_INSTR: next_state = IDLE;
      GRAB_DATA:  next_state = IDLE;
      SEND_DATA:  next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  // outputs from the current state
  always_comb begin
    // requester side defaults
    iwait    = 1'b0;
    dwait    = 1'b0;
    iload    = '0;
    dload    = '0;
    // ram side defaults
    ramREN   = 1'b0;
    ramWEN   = 1'b0;
    ramaddr  = '0;
    ramstore = '0;
    case (state)
      READ_INSTR: begin
        iwait   = 1'b1;
        ramREN  = 1'b1;
        ramaddr = iaddr;
      end
      GRAB_INSTR: begin
        // wait low for one cycle with the fetched word
        iload = load_q;
      end
      READ_DATA: begin
        dwait   = 1'b1;
        ramREN  = 1'b1;
        ramaddr = daddr;
      end
      GRAB_DATA: begin
        dload = load_q;
      end
      WRITE_DATA: begin
        dwait    = 1'b1;
        ramWEN   = 1'b1;
        ramaddr  = daddr;
        // store data travels with the write strobe
        ramstore = dstore;
      end
      SEND_DATA: begin
        // echo of the word that was written
        dload = load_q;
      end
      default: begin
        // idle keeps the defaults above
      end
    endcase
  end

  // state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // capture the ram word on the access cycle
  // the ram shows the stored word for writes as well
  always_ff @(posedge CLK) begin
    if (ramstate == ACCESS) begin
      load_q <= ramload;
    end
  end

endmodule

// ==== ram_model.sv ====
////////////////////
// word ram with a fixed access latency
// reports free, busy or access every cycle
// a strobe held from a free cycle completes RAM_LATENCY + 1 cycles later
////////////////////
`timescale 1ns/100ps

module ram_model
  import mem_types_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       ramREN,
  input  logic       ramWEN,
  input  addr_t      ramaddr,
  input  word_t      ramstore,
  output ram_state_t ramstate,
  output word_t      ramload
);

  // storage array
  word_t mem [RAM_DEPTH];

  // busy cycles still to go
  lat_cnt_t count_q;

  // any access requested this cycle
  logic strobe;
  // word index, upper address bits are dropped
  word_idx_t idx;

  assign strobe = ramREN | ramWEN;
  assign idx    = ramaddr[RAM_DEPTH_LOG2+1:2];

  // free / busy / access sequencing
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ramstate <= FREE;
      count_q  <= '0;
    end else begin
      case (ramstate)
        FREE: begin
          // first strobe cycle starts the countdown
          if (strobe) begin
            ramstate <= BUSY;
            count_q  <= lat_cnt_t'(RAM_LATENCY - 1);
          end
        end
        BUSY: begin
          if (!strobe) begin
            // requester gave up, abandon the access
            ramstate <= FREE;
          end else if (count_q == '0) begin
            ramstate <= ACCESS;
          end else begin
            count_q <= count_q - lat_cnt_t'(1);
          end
        end
        ACCESS: begin
          // one access cycle then back to free
          ramstate <= FREE;
        end
        default: begin
          ramstate <= FREE;
        end
      endcase
    end
  end

  // storage
  // cleared on reset, written at the edge that closes access
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if ((ramstate == ACCESS) && ramWEN) begin
      mem[idx] <= ramstore;
    end
  end

  // read port
  // only valid on the access cycle, zero otherwise
  always_comb begin
    ramload = '0;
    if (ramstate == ACCESS) begin
      // a write shows the word being stored
      if (ramWEN) begin
        ramload = ramstore;
      end else begin
        ramload = mem[idx];
      end
    end
  end

endmodule

// ==== memory_system.sv ====
////////////////////
// memory subsystem top level
// connects the arbiter to the latency ram model
// exposes the instruction and data requester ports
////////////////////
`timescale 1ns/100ps

module memory_system
  import mem_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // instruction port
  input  logic  iREN,
  input  addr_t iaddr,
  output logic  iwait,
  output word_t iload,
  // data port
  input  logic  dREN,
  input  logic  dWEN,
  input  addr_t daddr,
  input  word_t dstore,
  output logic  dwait,
  output word_t dload
);

  // ram bus between controller and ram
  logic       ram_ren;
  logic       ram_wen;
  addr_t      ram_addr;
  word_t      ram_store;
  ram_state_t ram_state;
  word_t      ram_load;

  // arbiter
  memory_control u_control (
    .CLK      (CLK),
    .nRST     (nRST),
    .iREN     (iREN),
    .iaddr    (iaddr),
    .dREN     (dREN),
    .dWEN     (dWEN),
    .daddr    (daddr),
    .dstore   (dstore),
    .iwait    (iwait),
    .dwait    (dwait),
    .iload    (iload),
    .dload    (dload),
    .ramREN   (ram_ren),
    .ramWEN   (ram_wen),
    .ramaddr  (ram_addr),
    .ramstore (ram_store),
    .ramstate (ram_state),
    .ramload  (ram_load)
  );

  // storage
  ram_model u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ram_ren),
    .ramWEN   (ram_wen),
    .ramaddr  (ram_addr),
    .ramstore (ram_store),
    .ramstate (ram_state),
    .ramload  (ram_load)
  );

endmodule

// ==== memory_control_properties.sv ====
////////////////////
// concurrent checks on the controller's ram-side protocol
// bound onto memory_control from the testbench
////////////////////
`timescale 1ns/100ps

module memory_control_properties
  import mem_types_pkg::*;
(
  input logic       CLK,
  input logic       nRST,
  input logic       ramREN,
  input logic       ramWEN,
  input addr_t      ramaddr,
  input word_t      ramstore,
  input ram_state_t ramstate,
  input logic       iwait,
  input logic       dwait
);

  // number of assertion failures so far
  int fail_count = 0;

  // any ram access requested
  logic strobe;

  assign strobe = ramREN | ramWEN;

  // read and write never requested together
  strobe_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramREN && ramWEN))
    else begin
      $error("ram read and write strobes high in the same cycle");
      fail_count++;
    end

  // address and store data held while the ram counts down
  request_held: assert property (@(posedge CLK) disable iff (!nRST)
    (strobe && (ramstate == BUSY)) |=> ($stable(ramaddr) && $stable(ramstore)))
    else begin
      $error("ram address or store data changed during a busy access");
      fail_count++;
    end

  // only one requester is ever being served
  single_wait: assert property (@(posedge CLK) disable iff (!nRST)
    !(iwait && dwait))
    else begin
      $error("instruction and data wait high together");
      fail_count++;
    end

  // strobe low in at least one of the two cycles after access
  strobe_release: assert property (@(posedge CLK) disable iff (!nRST)
    ($past(ramstate, 2) == ACCESS) |-> !(strobe && $past(strobe)))
    else begin
      $error("ram strobe still high two cycles after access");
      fail_count++;
    end

endmodule

// ==== memory_system_tb.sv ====
////////////////////
// self-checking testbench for the memory subsystem
// reset checks, random mixed traffic and port conflicts
// checked against a word model, properties bound on the controller
////////////////////
`timescale 1ns/100ps

module memory_system_tb
  import mem_types_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_BURST    = 8;
  // upper bound on the number of operations in the run
  localparam int OP_BUDGET    = 400;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + OP_BUDGET * (RAM_LATENCY + 4)) * CLK_PERIOD;

  logic  CLK;
  logic  nRST;
  logic  iREN;
  addr_t iaddr;
  logic  iwait;
  word_t iload;
  logic  dREN;
  logic  dWEN;
  addr_t daddr;
  word_t dstore;
  logic  dwait;
  word_t dload;

  // reference memory by word index, unwritten words read as zero
  word_t model [int];

  int cycle_count     = 0;
  int mismatch_errors = 0;
  int other_errors    = 0;

  memory_system u_memory_system (
    .CLK    (CLK),
    .nRST   (nRST),
    .iREN   (iREN),
    .iaddr  (iaddr),
    .iwait  (iwait),
    .iload  (iload),
    .dREN   (dREN),
    .dWEN   (dWEN),
    .daddr  (daddr),
    .dstore (dstore),
    .dwait  (dwait),
    .dload  (dload)
  );

  bind memory_control memory_control_properties u_control_props (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramstate (ramstate),
    .iwait    (iwait),
    .dwait    (dwait)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // cycle stamp, read at falling edges
  always @(posedge CLK) cycle_count <= cycle_count + 1;

  // word index comes from address bits 7 down to 2
  function automatic word_t model_read(input addr_t addr);
    int idx;
    idx = int'(addr[RAM_DEPTH_LOG2+1:2]);
    if (model.exists(idx)) begin
      return model[idx];
    end
    return '0;
  endfunction

  function automatic int total_errors();
    return mismatch_errors + other_errors + u_memory_system.u_control.u_control_props.fail_count;
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("mismatch %s: expected %h actual %h", name, expected, actual);
      mismatch_errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("mismatch %s: expected %0d actual %0d", name, expected, actual);
      mismatch_errors++;
    end
  endtask

  task automatic report_counts();
    $display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_errors, other_errors,
             u_memory_system.u_control.u_control_props.fail_count);
  endtask

  // follow one request from its request edge to the cycle with wait low
  // a low wait only counts once the port has seen wait high
  task automatic await_completion(input logic data_port, input string name,
                                  input logic expect_now, output word_t word,
                                  output int done_cycle);
    int   high_cycles;
    logic seen_high;
    logic first;
    logic done;
    logic wait_now;
    high_cycles = 0;
    seen_high   = 1'b0;
    first       = 1'b1;
    done        = 1'b0;
    // the next rising edge samples the request
    @(posedge CLK);
    while (!done) begin
      @(negedge CLK);
      wait_now = data_port ? dwait : iwait;
      if (first && expect_now) begin
        assert (wait_now) else begin
          $display("%s: request was not taken on its request edge", name);
          other_errors++;
        end
      end
      first = 1'b0;
      if (wait_now) begin
        seen_high = 1'b1;
        high_cycles++;
        @(posedge CLK);
      end else if (seen_high) begin
        done = 1'b1;
      end else begin
        // lost arbitration or not sampled yet
        @(posedge CLK);
      end
    end
    word       = data_port ? dload : iload;
    done_cycle = cycle_count;
    // wait high from the request edge until the grab or send state
    check_count($sformatf("%s latency", name), RAM_LATENCY + 2, high_cycles);
  endtask

  task automatic data_write(input addr_t addr, input word_t word, input string name,
                            input logic expect_now, output int done_cycle);
    word_t echo;
    @(posedge CLK);
    #DRIVE_DELAY;
    dWEN   = 1'b1;
    daddr  = addr;
    dstore = word;
    await_completion(1'b1, name, expect_now, echo, done_cycle);
    check_word($sformatf("%s echo", name), word, echo);
    // model follows the ram only once the write has completed
    model[int'(addr[RAM_DEPTH_LOG2+1:2])] = word;
    @(posedge CLK);
    #DRIVE_DELAY;
    dWEN = 1'b0;
  endtask

  task automatic data_read(input addr_t addr, input string name,
                           input logic expect_now, output int done_cycle);
    word_t got;
    @(posedge CLK);
    #DRIVE_DELAY;
    dREN  = 1'b1;
    daddr = addr;
    await_completion(1'b1, name, expect_now, got, done_cycle);
    check_word(name, model_read(addr), got);
    @(posedge CLK);
    #DRIVE_DELAY;
    dREN = 1'b0;
  endtask

  task automatic instr_fetch(input addr_t addr, input string name,
                             input logic expect_now, output int done_cycle);
    word_t got;
    @(posedge CLK);
    #DRIVE_DELAY;
    iREN  = 1'b1;
    iaddr = addr;
    await_completion(1'b0, name, expect_now, got, done_cycle);
    // expected value taken at completion, after any earlier data write
    check_word(name, model_read(addr), got);
    @(posedge CLK);
    #DRIVE_DELAY;
    iREN = 1'b0;
  endtask

  initial begin
    int    done_d;
    int    done_i;
    int    op;
    addr_t addr;
    addr_t fetch_addr;
    word_t data;
    void'($urandom(32'h5410));
    CLK    = 1'b0;
    nRST   = 1'b0;
    iREN   = 1'b0;
    iaddr  = '0;
    dREN   = 1'b0;
    dWEN   = 1'b0;
    daddr  = '0;
    dstore = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    nRST = 1'b1;

    // outputs idle and zero after reset
    @(negedge CLK);
    check_word("reset iwait", '0, word_t'(iwait));
    check_word("reset dwait", '0, word_t'(dwait));
    check_word("reset iload", '0, iload);
    check_word("reset dload", '0, dload);
    // every word reads zero, through both ports
    for (int i = 0; i < RAM_DEPTH; i++) begin
      addr = $urandom;
      addr[RAM_DEPTH_LOG2+1:2] = word_idx_t'(i);
      if (i % 2 == 0) begin
        data_read(addr, $sformatf("reset read %0d", i), 1'b1, done_d);
      end else begin
        instr_fetch(addr, $sformatf("reset fetch %0d", i), 1'b1, done_i);
      end
    end

    // write, read back with other upper bits, then fetch the same word
    for (int i = 0; i < 4; i++) begin
      addr = $urandom;
      data = $urandom;
      data_write(addr, data, $sformatf("directed write %0d", i), 1'b1, done_d);
      data_read(addr ^ 32'hFFFF_FF00, $sformatf("directed read %0d", i), 1'b1, done_d);
      instr_fetch(addr, $sformatf("directed fetch %0d", i), 1'b1, done_i);
    end

    // random mixed traffic, upper address bits random too
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op   = $urandom_range(0, 2);
      addr = $urandom;
      data = $urandom;
      case (op)
        0: data_write(addr, data, $sformatf("random write %0d", n), 1'b1, done_d);
        1: data_read(addr, $sformatf("random read %0d", n), 1'b1, done_d);
        default: instr_fetch(addr, $sformatf("random fetch %0d", n), 1'b1, done_i);
      endcase
    end

    // both ports raised together, data first and fetch in the next access
    for (int k = 0; k < NUM_BURST; k++) begin
      addr       = $urandom;
      data       = $urandom;
      fetch_addr = $urandom;
      // even pairs fetch the word the data port touches
      if (k % 2 == 0) begin
        fetch_addr[RAM_DEPTH_LOG2+1:2] = addr[RAM_DEPTH_LOG2+1:2];
      end
      fork
        begin
          if (k % 4 < 2) begin
            data_write(addr, data, $sformatf("burst write %0d", k), 1'b1, done_d);
          end else begin
            data_read(addr, $sformatf("burst read %0d", k), 1'b1, done_d);
          end
        end
        instr_fetch(fetch_addr, $sformatf("burst fetch %0d", k), 1'b0, done_i);
      join
      // grab cycle and one idle cycle separate the two accesses
      check_count($sformatf("burst %0d fetch after data", k), RAM_LATENCY + 4,
                  done_i - done_d);
    end

    report_counts();
    if (total_errors() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the test sequences did not finish", WATCHDOG_NS);
    report_counts();
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== flist.f ====
mem_types_pkg.sv
memory_control.sv
ram_model.sv
memory_system.sv
memory_control_properties.sv
memory_system_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = memory_system_tb
FILELIST = flist.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Checks failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails when the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with $$status"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
